/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f project.f --top-module copro_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vcopro_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

/* project.f */
rtl/copro_pkg.sv
rtl/dual_port_ram.sv
rtl/inst_sequencer.sv
rtl/index_fifo.sv
rtl/slot_serializer.sv
rtl/interrupt_tx.sv
rtl/copro_top.sv
sim/tb_clock.sv
sim/copro_tb.sv

/* rtl/copro_pkg.sv */
/*
  Shared types of the coprocessor control path. RAM addresses are 16 bits wide.
  A slot holds a 3-bit point type and a 381-bit field element.
*/
package copro_pkg;

  localparam int ADDR_BITS = 16;
  localparam int FE_BITS   = 381;
  localparam logic [15:0] IRQ_MSG_CODE = 16'h0106;

  typedef enum logic [2:0] {
    SCALAR, FE, FE2, FP_AF, FP_JB, FP2_AF, FP2_JB
  } point_type_e;

  // Unlisted opcodes run as NOOP_WAIT
  typedef enum logic [7:0] {
    NOOP_WAIT      = 8'd0,
    COPY_REG       = 8'd1,
    SEND_INTERRUPT = 8'd6
  } opcode_e;

  typedef enum logic [1:0] {
    HOST_INST, HOST_DATA, HOST_START
  } host_dest_e;

  typedef struct packed {
    point_type_e          pt;
    logic [FE_BITS-1:0]   dat;
  } slot_t;

  typedef struct packed {
    opcode_e              code;
    logic [15:0]          a;
    logic [15:0]          b;
  } inst_t;

  // Instructions use payload[39:0], HOST_START uses addr only
  typedef struct packed {
    host_dest_e           dest;
    logic [ADDR_BITS-1:0] addr;
    logic [383:0]         payload;
  } host_wr_t;

  typedef struct packed {
    point_type_e          pt;
    logic [15:0]          idx;
  } idx_desc_t;

  typedef struct packed {
    slot_t                slot;
    logic                 last;
  } slot_beat_t;

  typedef struct packed {
    logic [63:0]          dat;
    logic                 sop;
    logic                 eop;
  } tx_beat_t;

  typedef struct packed {
    logic [15:0]          msg_code;
    logic [15:0]          byte_len;
    logic [7:0]           slot_cnt;
    logic [7:0]           pt_type;
    logic [15:0]          msg_idx;
  } irq_hdr_t;

  // Number of consecutive slots a value of this type occupies
  function automatic logic [7:0] slot_count(point_type_e pt);
    case (pt)
      SCALAR, FE:  return 8'd1;
      FE2, FP_AF:  return 8'd2;
      FP_JB:       return 8'd3;
      FP2_AF:      return 8'd4;
      FP2_JB:      return 8'd6;
      default:     return 8'd1;
    endcase
  endfunction

endpackage

/* rtl/copro_top.sv */
/*
  Coprocessor control path. Host writes are accepted every cycle and should
  only be issued while o_busy is low. RAM contents start undefined.
*/
`timescale 1ns/1ps

module copro_top #(
  parameter int RD_LAT     = 2,
  parameter int IDX_DEPTH  = 4,
  parameter int INST_DEPTH = 1024,
  parameter int DATA_DEPTH = 1024
) (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_host_val,
  input  copro_pkg::host_wr_t i_host,
  output logic                o_tx_val,
  output copro_pkg::tx_beat_t o_tx,
  input  logic                i_tx_rdy,
  output logic                o_busy
);
  import copro_pkg::*;

  logic [ADDR_BITS-1:0] inst_addr;
  inst_t                inst_rdata;
  logic [ADDR_BITS-1:0] slot_addr;
  logic                 slot_we;
  slot_t                slot_wdata;
  slot_t                slot_rdata;

  // Sequencer to FIFO and serializer
  logic                 seq_idx_val, seq_idx_rdy;
  idx_desc_t            seq_idx;
  logic                 seq_slot_val, seq_slot_rdy;
  slot_beat_t           seq_slot;

  // FIFO and serializer to transmitter
  logic                 fifo_val, fifo_rdy;
  idx_desc_t            fifo_dat;
  logic                 ser_val, ser_rdy;
  tx_beat_t             ser_beat;

  dual_port_ram #(
    .WIDTH($bits(inst_t)), .DEPTH(INST_DEPTH), .RD_LAT(RD_LAT), .WRITE_SEL(HOST_INST)
  ) inst_ram (
    .i_clk(i_clk), .i_host_val(i_host_val), .i_host(i_host),
    .i_addr(inst_addr), .i_we(1'b0), .i_wdata('0), .o_rdata(inst_rdata)
  );

  dual_port_ram #(
    .WIDTH($bits(slot_t)), .DEPTH(DATA_DEPTH), .RD_LAT(RD_LAT), .WRITE_SEL(HOST_DATA)
  ) slot_ram (
    .i_clk(i_clk), .i_host_val(i_host_val), .i_host(i_host),
    .i_addr(slot_addr), .i_we(slot_we), .i_wdata(slot_wdata), .o_rdata(slot_rdata)
  );

  inst_sequencer #(.RD_LAT(RD_LAT)) inst_sequencer_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_host_val(i_host_val), .i_host(i_host),
    .o_inst_addr(inst_addr), .i_inst_rdata(inst_rdata),
    .o_slot_addr(slot_addr), .o_slot_we(slot_we), .o_slot_wdata(slot_wdata),
    .i_slot_rdata(slot_rdata),
    .o_idx_val(seq_idx_val), .o_idx(seq_idx), .i_idx_rdy(seq_idx_rdy),
    .o_slot_val(seq_slot_val), .o_slot(seq_slot), .i_slot_rdy(seq_slot_rdy),
    .o_busy(o_busy)
  );

  index_fifo #(.DEPTH(IDX_DEPTH)) index_fifo_i (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_val(seq_idx_val), .i_dat(seq_idx), .o_rdy(seq_idx_rdy),
    .o_val(fifo_val), .o_dat(fifo_dat), .i_rdy(fifo_rdy)
  );

  slot_serializer slot_serializer_i (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_val(seq_slot_val), .i_slot(seq_slot), .o_rdy(seq_slot_rdy),
    .o_val(ser_val), .o_beat(ser_beat), .i_rdy(ser_rdy)
  );

  interrupt_tx interrupt_tx_i (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_idx_val(fifo_val), .i_idx(fifo_dat), .o_idx_rdy(fifo_rdy),
    .i_beat_val(ser_val), .i_beat(ser_beat), .o_beat_rdy(ser_rdy),
    .o_tx_val(o_tx_val), .o_tx(o_tx), .i_tx_rdy(i_tx_rdy)
  );

endmodule

/* rtl/dual_port_ram.sv */
/*
  Host write port plus one core read/write port. No reset, so contents are
  undefined until written. Reads are read-first; RD_LAT must be at least 1.
*/
`timescale 1ns/1ps

module dual_port_ram #(
  parameter int                   WIDTH     = 384,
  parameter int                   DEPTH     = 1024,
  parameter int                   RD_LAT    = 2,
  parameter copro_pkg::host_dest_e WRITE_SEL = copro_pkg::HOST_DATA
) (
  input  logic                             i_clk,
  input  logic                             i_host_val,
  input  copro_pkg::host_wr_t              i_host,
  input  logic [copro_pkg::ADDR_BITS-1:0]  i_addr,
  input  logic                             i_we,
  input  logic [WIDTH-1:0]                 i_wdata,
  output logic [WIDTH-1:0]                 o_rdata
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [WIDTH-1:0] rd_pipe [RD_LAT];
  logic             host_we;

  // Only commands addressed to this RAM land here
  assign host_we = i_host_val && (i_host.dest == WRITE_SEL);

  always_ff @(posedge i_clk) begin
    if (host_we) begin
      mem[i_host.addr[AW-1:0]] <= i_host.payload[WIDTH-1:0];
    end
    if (i_we) begin
      mem[i_addr[AW-1:0]] <= i_wdata;
    end
    rd_pipe[0] <= mem[i_addr[AW-1:0]];
    for (int i = 1; i < RD_LAT; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign o_rdata = rd_pipe[RD_LAT-1];

endmodule

/* rtl/index_fifo.sv */
/*
  Descriptor FIFO with a combinational read port. DEPTH need not be a
  power of two.
*/
`timescale 1ns/1ps

module index_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_val,
  input  copro_pkg::idx_desc_t i_dat,
  output logic                 o_rdy,
  output logic                 o_val,
  output copro_pkg::idx_desc_t o_dat,
  input  logic                 i_rdy
);
  import copro_pkg::*;

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PW-1:0] LAST_PTR = PW'(DEPTH - 1);

  idx_desc_t     mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;
  logic          push;
  logic          pop;

  assign o_rdy = (count != (PW+1)'(DEPTH));
  assign o_val = (count != '0);
  assign o_dat = mem[rd_ptr];
  assign push  = i_val && o_rdy;
  assign pop   = o_val && i_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) mem[wr_ptr] <= i_dat;
  end

endmodule

/* rtl/inst_sequencer.sv */
/*
  Runs programs from the instruction RAM after HOST_START. Only one RAM read
  is in flight at a time. Halts on NOOP_WAIT or any unknown opcode.
*/
`timescale 1ns/1ps

module inst_sequencer #(
  parameter int RD_LAT = 2
) (
  input  logic                             i_clk,
  input  logic                             i_rst,
  input  logic                             i_host_val,
  input  copro_pkg::host_wr_t              i_host,
  output logic [copro_pkg::ADDR_BITS-1:0]  o_inst_addr,
  input  copro_pkg::inst_t                 i_inst_rdata,
  output logic [copro_pkg::ADDR_BITS-1:0]  o_slot_addr,
  output logic                             o_slot_we,
  output copro_pkg::slot_t                 o_slot_wdata,
  input  copro_pkg::slot_t                 i_slot_rdata,
  output logic                             o_idx_val,
  output copro_pkg::idx_desc_t             o_idx,
  input  logic                             i_idx_rdy,
  output logic                             o_slot_val,
  output copro_pkg::slot_beat_t            o_slot,
  input  logic                             i_slot_rdy,
  output logic                             o_busy
);
  import copro_pkg::*;

  typedef enum logic [2:0] {IDLE, FETCH, COPY, SEND_IDX, SEND_SLOTS} state_e;

  state_e               state;
  inst_t                cur_inst;
  logic [ADDR_BITS-1:0] pc;
  logic [RD_LAT-1:0]    rd_sr;
  logic                 rd_issue;
  logic                 rd_done;
  logic [7:0]           slots_left;
  logic                 send_done;

  assign o_inst_addr = pc;
  assign o_busy      = (state != IDLE);
  assign rd_done     = rd_sr[RD_LAT-1];

  // Single outstanding read, slot reads wait for room in the output register
  always_comb begin
    rd_issue = 1'b0;
    if (rd_sr == '0) begin
      case (state)
        FETCH, COPY, SEND_IDX: rd_issue = 1'b1;
        SEND_SLOTS:            rd_issue = (slots_left != 8'd0) && (!o_slot_val || i_slot_rdy);
        default:               rd_issue = 1'b0;
      endcase
    end
  end

  // All slots read, handed over, and the descriptor pushed
  assign send_done = (slots_left == 8'd0) && (rd_sr == '0) && !o_slot_val && !o_idx_val;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= IDLE;
      pc         <= '0;
      rd_sr      <= '0;
      slots_left <= '0;
      o_slot_we  <= 1'b0;
      o_idx_val  <= 1'b0;
      o_slot_val <= 1'b0;
    end else begin
      rd_sr     <= (rd_sr << 1) | RD_LAT'(rd_issue);
      o_slot_we <= 1'b0;
      if (o_idx_val && i_idx_rdy) o_idx_val <= 1'b0;
      if (o_slot_val && i_slot_rdy) o_slot_val <= 1'b0;

      case (state)
        IDLE: begin
          if (i_host_val && i_host.dest == HOST_START) begin
            pc    <= i_host.addr;
            state <= FETCH;
          end
        end
        FETCH: begin
          if (rd_done) begin
            case (i_inst_rdata.code)
              COPY_REG:       state <= COPY;
              SEND_INTERRUPT: state <= SEND_IDX;
              default:        state <= IDLE;
            endcase
          end
        end
        COPY: begin
          // Write of slot b lands during the next fetch
          if (rd_done) begin
            o_slot_we <= 1'b1;
            pc        <= pc + 1'b1;
            state     <= FETCH;
          end
        end
        SEND_IDX: begin
          if (rd_done) begin
            o_idx_val  <= 1'b1;
            slots_left <= slot_count(i_slot_rdata.pt);
            state      <= SEND_SLOTS;
          end
        end
        SEND_SLOTS: begin
          if (rd_issue) slots_left <= slots_left - 8'd1;
          if (rd_done) o_slot_val <= 1'b1;
          if (send_done) begin
            pc    <= pc + 1'b1;
            state <= FETCH;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Addresses and payload
  always_ff @(posedge i_clk) begin
    if (state == FETCH && rd_done) begin
      cur_inst    <= i_inst_rdata;
      o_slot_addr <= i_inst_rdata.a;
    end
    if (state == COPY && rd_done) begin
      o_slot_addr  <= cur_inst.b;
      o_slot_wdata <= i_slot_rdata;
    end
    if (state == SEND_IDX && rd_done) begin
      o_idx.pt  <= i_slot_rdata.pt;
      o_idx.idx <= cur_inst.b;
    end
    if (state == SEND_SLOTS && rd_issue) begin
      o_slot_addr <= o_slot_addr + 1'b1;
    end
    if (state == SEND_SLOTS && rd_done) begin
      o_slot.slot <= i_slot_rdata;
      o_slot.last <= (slots_left == 8'd0);
    end
  end

endmodule

/* rtl/interrupt_tx.sv */
/*
  One message per descriptor: a header beat with sop, then serializer beats
  up to eop. Output is a single register that holds while not taken.
*/
`timescale 1ns/1ps

module interrupt_tx (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_idx_val,
  input  copro_pkg::idx_desc_t i_idx,
  output logic                 o_idx_rdy,
  input  logic                 i_beat_val,
  input  copro_pkg::tx_beat_t  i_beat,
  output logic                 o_beat_rdy,
  output logic                 o_tx_val,
  output copro_pkg::tx_beat_t  o_tx,
  input  logic                 i_tx_rdy
);
  import copro_pkg::*;

  typedef enum logic [1:0] {WAIT_IDX, SEND_HDR, SEND_DATA} state_e;

  state_e     state;
  irq_hdr_t   hdr;
  irq_hdr_t   hdr_next;
  logic [7:0] idx_slots;
  logic       out_free;

  assign out_free   = !o_tx_val || i_tx_rdy;
  assign o_idx_rdy  = (state == WAIT_IDX);
  assign o_beat_rdy = (state == SEND_DATA) && out_free;
  assign idx_slots  = slot_count(i_idx.pt);

  // 48 bytes per slot
  always_comb begin
    hdr_next.msg_code = IRQ_MSG_CODE;
    hdr_next.byte_len = 16'(idx_slots) * 16'd48;
    hdr_next.slot_cnt = idx_slots;
    hdr_next.pt_type  = 8'(i_idx.pt);
    hdr_next.msg_idx  = i_idx.idx;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= WAIT_IDX;
      o_tx_val <= 1'b0;
    end else begin
      if (o_tx_val && i_tx_rdy) o_tx_val <= 1'b0;
      case (state)
        WAIT_IDX: begin
          if (i_idx_val) state <= SEND_HDR;
        end
        SEND_HDR: begin
          if (out_free) begin
            o_tx_val <= 1'b1;
            state    <= SEND_DATA;
          end
        end
        SEND_DATA: begin
          if (out_free && i_beat_val) begin
            o_tx_val <= 1'b1;
            if (i_beat.eop) state <= WAIT_IDX;
          end
        end
        default: state <= WAIT_IDX;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == WAIT_IDX && i_idx_val) begin
      hdr <= hdr_next;
    end
    if (state == SEND_HDR && out_free) begin
      o_tx.dat <= hdr;
      o_tx.sop <= 1'b1;
      o_tx.eop <= 1'b0;
    end else if (state == SEND_DATA && out_free && i_beat_val) begin
      o_tx <= i_beat;
    end
  end

endmodule

/* rtl/slot_serializer.sv */
/*
  Splits one 384-bit slot into six 64-bit beats, low bits first. The next
  slot can load on the cycle the sixth beat leaves. sop is always low.
*/
`timescale 1ns/1ps

module slot_serializer (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_val,
  input  copro_pkg::slot_beat_t i_slot,
  output logic                  o_rdy,
  output logic                  o_val,
  output copro_pkg::tx_beat_t   o_beat,
  input  logic                  i_rdy
);
  import copro_pkg::*;

  localparam int BEATS = $bits(slot_t) / 64;
  localparam logic [2:0] LAST_BEAT = 3'(BEATS - 1);

  logic [$bits(slot_t)-1:0] shreg;
  logic                     last;
  logic                     full;
  logic [2:0]               beat_cnt;
  logic                     load;
  logic                     take;

  assign take  = full && i_rdy;
  assign o_rdy = !full || (take && beat_cnt == LAST_BEAT);
  assign load  = i_val && o_rdy;
  assign o_val = full;

  always_comb begin
    o_beat.dat = shreg[63:0];
    o_beat.sop = 1'b0;
    // eop only closes the final slot of a point
    o_beat.eop = last && (beat_cnt == LAST_BEAT);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      full     <= 1'b0;
      beat_cnt <= '0;
    end else if (load) begin
      full     <= 1'b1;
      beat_cnt <= '0;
    end else if (take) begin
      beat_cnt <= beat_cnt + 3'd1;
      if (beat_cnt == LAST_BEAT) full <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (load) begin
      shreg <= i_slot.slot;
      last  <= i_slot.last;
    end else if (take) begin
      shreg <= shreg >> 64;
    end
  end

endmodule

/* sim/copro_tb.sv */
/*
  Directed testbench for copro_top. Slot contents are mirrored in a local model.
  Host writes are only issued while the DUT is idle.
*/
`timescale 1ns/1ps

module copro_tb;
  import copro_pkg::*;

  logic         clk;
  logic         rst;
  logic         host_val;
  host_wr_t     host;
  logic         tx_val;
  tx_beat_t     tx;
  logic         tx_rdy;
  logic         busy;
  int           errors = 0;
  int           checks = 0;
  logic [31:0]  rng = 32'hd343783e;
  // Slot image, point type in the top 3 bits
  logic [383:0] model [64];
  logic [63:0]  rx_dat [$];
  logic         rx_sop [$];
  logic         rx_eop [$];

  tb_clock clock_i (.o_clk(clk));

  copro_top #(
    .RD_LAT(2), .IDX_DEPTH(4), .INST_DEPTH(64), .DATA_DEPTH(64)
  ) copro_top_i (
    .i_clk(clk), .i_rst(rst), .i_host_val(host_val), .i_host(host),
    .o_tx_val(tx_val), .o_tx(tx), .i_tx_rdy(tx_rdy), .o_busy(busy)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Slots per value, in point type order
  function automatic int slots_of(input point_type_e pt);
    case (pt)
      SCALAR, FE: return 1;
      FE2, FP_AF: return 2;
      FP_JB:      return 3;
      FP2_AF:     return 4;
      default:    return 6;
    endcase
  endfunction

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic next_rand(output logic [31:0] r);
    rng = xorshift(rng);
    r = rng;
  endtask

  task automatic host_write(input host_dest_e dest, input logic [15:0] addr,
                            input logic [383:0] payload);
    @(posedge clk);
    host_val     <= 1'b1;
    host.dest    <= dest;
    host.addr    <= addr;
    host.payload <= payload;
    @(posedge clk);
    host_val <= 1'b0;
  endtask

  task automatic write_slot(input int addr, input point_type_e pt);
    logic [383:0] s;
    logic [31:0]  r;
    for (int i = 0; i < 12; i++) begin
      next_rand(r);
      s[32 * i +: 32] = r;
    end
    s[383:381] = pt;
    model[addr] = s;
    host_write(HOST_DATA, 16'(addr), s);
  endtask

  task automatic write_inst(input int addr, input logic [7:0] code,
                            input logic [15:0] a, input logic [15:0] b);
    host_write(HOST_INST, 16'(addr), {344'd0, code, a, b});
  endtask

  task automatic start(input logic [15:0] ptr);
    host_write(HOST_START, ptr, '0);
  endtask

  // Gathers one packet up to eop, beats are taken on the edge after the sample
  task automatic collect_message(input bit use_rand);
    logic [31:0] r;
    int          idle;
    bit          done;
    rx_dat.delete();
    rx_sop.delete();
    rx_eop.delete();
    idle = 0;
    done = 1'b0;
    while (!done && idle < 3000) begin
      @(posedge clk);
      if (use_rand) begin
        next_rand(r);
        tx_rdy <= r[0];
      end else begin
        tx_rdy <= 1'b1;
      end
      @(negedge clk);
      if (tx_val && tx_rdy) begin
        rx_dat.push_back(tx.dat);
        rx_sop.push_back(tx.sop);
        rx_eop.push_back(tx.eop);
        done = tx.eop;
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (!done) begin
      errors++;
      $display("timeout: packet did not end, %0d beats seen", rx_dat.size());
    end
  endtask

  task automatic check_packet(input point_type_e pt, input logic [15:0] idx, input int base);
    int           n;
    logic [383:0] s;
    n = slots_of(pt);
    check_eq("beat count on o_tx", 64'(rx_dat.size()), 64'(1 + 6 * n));
    if (rx_dat.size() != 1 + 6 * n) return;
    check_eq("o_tx.dat header", rx_dat[0],
             {IRQ_MSG_CODE, 16'(n * 48), 8'(n), 5'd0, pt, idx});
    check_eq("o_tx.sop header", 64'(rx_sop[0]), 64'd1);
    check_eq("o_tx.eop header", 64'(rx_eop[0]), 64'd0);
    for (int k = 0; k < 6 * n; k++) begin
      s = model[base + k / 6];
      check_eq($sformatf("o_tx.dat beat %0d", k), rx_dat[k + 1], s[64 * (k % 6) +: 64]);
      check_eq($sformatf("o_tx.sop beat %0d", k), 64'(rx_sop[k + 1]), 64'd0);
      check_eq($sformatf("o_tx.eop beat %0d", k), 64'(rx_eop[k + 1]), 64'(k == 6 * n - 1));
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (busy && n < 5000) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      errors++;
      $display("timeout: sequencer still busy after %0d cycles", n);
    end
  endtask

  task automatic expect_quiet(input int cycles);
    int seen;
    seen = 0;
    repeat (cycles) begin
      @(posedge clk);
      tx_rdy <= 1'b1;
      @(negedge clk);
      if (tx_val) seen++;
    end
    check_eq("o_tx_val cycles while quiet", 64'(seen), 64'd0);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) $display("test %s: passed", name);
    else $display("test %s: %0d errors", name, errors - errs_before);
  endtask

  task automatic reset_state();
    int e0;
    e0 = errors;
    @(negedge clk);
    check_eq("o_tx_val", 64'(tx_val), 64'd0);
    check_eq("o_busy", 64'(busy), 64'd0);
    expect_quiet(20);
    report_test("reset state", e0);
  endtask

  task automatic copy_then_send();
    int e0;
    e0 = errors;
    write_slot(3, FE);
    write_inst(0, COPY_REG, 16'd3, 16'd10);
    write_inst(1, SEND_INTERRUPT, 16'd10, 16'd7);
    write_inst(2, NOOP_WAIT, 16'd0, 16'd0);
    model[10] = model[3];
    start(16'd0);
    collect_message(1'b0);
    check_packet(FE, 16'd7, 10);
    wait_idle();
    expect_quiet(20);
    report_test("copy then send", e0);
  endtask

  task automatic multi_slot_backpressure();
    int e0;
    e0 = errors;
    for (int i = 0; i < 6; i++) write_slot(20 + i, FP2_JB);
    write_inst(4, SEND_INTERRUPT, 16'd20, 16'd9);
    write_inst(5, NOOP_WAIT, 16'd0, 16'd0);
    start(16'd4);
    collect_message(1'b1);
    check_packet(FP2_JB, 16'd9, 20);
    wait_idle();
    report_test("multi-slot point under back-pressure", e0);
  endtask

  task automatic queued_messages();
    int e0;
    e0 = errors;
    write_slot(30, SCALAR);
    for (int i = 31; i < 33; i++) write_slot(i, FP_AF);
    for (int i = 33; i < 36; i++) write_slot(i, FP_JB);
    write_inst(8, SEND_INTERRUPT, 16'd30, 16'd1);
    write_inst(9, SEND_INTERRUPT, 16'd31, 16'd2);
    write_inst(10, SEND_INTERRUPT, 16'd33, 16'd3);
    write_inst(11, NOOP_WAIT, 16'd0, 16'd0);
    @(posedge clk);
    tx_rdy <= 1'b0;
    start(16'd8);
    repeat (200) @(posedge clk);
    @(negedge clk);
    // Header waits in the output register, sequencer stalled behind it
    check_eq("o_tx_val during stall", 64'(tx_val), 64'd1);
    check_eq("o_tx.sop during stall", 64'(tx.sop), 64'd1);
    check_eq("o_busy during stall", 64'(busy), 64'd1);
    collect_message(1'b0);
    check_packet(SCALAR, 16'd1, 30);
    collect_message(1'b0);
    check_packet(FP_AF, 16'd2, 31);
    collect_message(1'b0);
    check_packet(FP_JB, 16'd3, 33);
    wait_idle();
    expect_quiet(20);
    report_test("queued messages", e0);
  endtask

  task automatic halt_and_restart();
    int e0;
    e0 = errors;
    write_inst(12, SEND_INTERRUPT, 16'd30, 16'd5);
    write_inst(13, 8'h2a, 16'd31, 16'd6);
    write_inst(14, SEND_INTERRUPT, 16'd31, 16'd6);
    write_inst(15, NOOP_WAIT, 16'd0, 16'd0);
    start(16'd12);
    collect_message(1'b0);
    check_packet(SCALAR, 16'd5, 30);
    wait_idle();
    expect_quiet(50);
    start(16'd14);
    collect_message(1'b0);
    check_packet(FP_AF, 16'd6, 31);
    wait_idle();
    expect_quiet(20);
    report_test("halt and restart", e0);
  endtask

  initial begin
    rst      = 1'b1;
    host_val = 1'b0;
    host     = '0;
    tx_rdy   = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    reset_state();
    copy_then_send();
    multi_slot_backpressure();
    queued_messages();
    halt_and_restart();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Cycle limit for the whole run
  initial begin
    repeat (100000) @(posedge clk);
    $display("timeout: simulation ran past its cycle limit");
    $display("Something failed");
    $finish;
  end

endmodule

/* sim/tb_clock.sv */
/*
  Free-running testbench clock, low at time zero.
*/
`timescale 1ns/1ps

module tb_clock #(
  parameter real PERIOD = 100.0
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2.0) o_clk = ~o_clk;
  end

endmodule
